// File: Makefile
VERILATOR ?= verilator
TOP       ?= qspinor_tb
FLIST     ?= all.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing
PASS_MSG  ?= ** PASS **

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FLIST)

$(OBJ_DIR)/V$(TOP): $(FLIST)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

// File: all.f
source/qspinor_pkg.sv
source/qspinor_io.sv
source/qspinor_bus_read.sv
source/qspinor_ip_access.sv
source/qspinor_controller.sv
bench/qspinor_flash_model.sv
bench/qspinor_tb.sv

// File: bench/qspinor_flash_model.sv
module qspinor_flash_model (
    input  logic        qspi_csb,
    input  logic        qspi_sclk,
    input  logic [3:0]  qspi_dir,
    input  logic [3:0]  qspi_mosi,
    output logic [3:0]  qspi_miso,
    input  logic        raw_mode,  // 1 = record and return raw bytes, x1 only
    input  logic [2:0]  cmd_w,     // lanes per phase, 1, 2 or 4
    input  logic [2:0]  addr_w,
    input  logic [2:0]  data_w,
    input  logic [3:0]  dmy_n,
    output logic [7:0]  cmd_q,
    output logic [23:0] addr_q,
    output logic [7:0]  raw_q,
    output int          edges
);
    logic [7:0] raw_sr;
    int         raw_bits;
    int         cmd_e;
    int         addr_e;
    int         pre;

    always_comb begin
        cmd_e  = 8 / int'(cmd_w);
        addr_e = 24 / int'(addr_w);
        pre    = cmd_e + addr_e + int'(dmy_n);  // edges before the data phase
    end

    function automatic logic [23:0] shift_in(input logic [23:0] v, input int k,
                                             input logic [3:0] mosi);
        shift_in = (v << k) | 24'(mosi & 4'((1 << k) - 1));
    endfunction

    // put beat b of the data stream on miso, msb first
    function automatic logic [3:0] beat_bits(input logic [7:0] b, input int k, input int j);
        logic [7:0] s;
        s = b >> (8 - k * (j + 1));
        case (k)
            1:       beat_bits = {2'b00, s[0], 1'b0};  // x1 data on io1
            2:       beat_bits = {2'b00, s[1:0]};
            default: beat_bits = s[3:0];
        endcase
    endfunction

    task automatic present(input int b);
        int         k;
        logic [7:0] data;
        k = raw_mode ? 1 : int'(data_w);
        if (raw_mode) data = 8'h3c;
        else data = 8'(addr_q + 24'(b / (8 / k))) ^ 8'ha5;
        qspi_miso = beat_bits(data, k, b % (8 / k));
    endtask

    initial qspi_miso = 4'h0;

    // select only falls while sclk is low
    always @(negedge qspi_csb or posedge qspi_sclk) begin
        if (!qspi_sclk) begin
            edges    = 0;
            raw_bits = 0;
            present(0);
        end else if (!qspi_csb) begin
            if (raw_mode) begin
                if (qspi_dir != 4'h0) begin
                    raw_sr   = 8'(shift_in(24'(raw_sr), 1, qspi_mosi));
                    raw_bits = raw_bits + 1;
                    if (raw_bits == 8) begin
                        raw_q    = raw_sr;
                        raw_bits = 0;
                    end
                end
            end else if (edges < cmd_e) begin
                cmd_q = 8'(shift_in(24'(cmd_q), int'(cmd_w), qspi_mosi));
            end else if (edges < cmd_e + addr_e) begin
                addr_q = shift_in(addr_q, int'(addr_w), qspi_mosi);
            end
            edges = edges + 1;
        end
    end

    always @(negedge qspi_sclk) begin
        if (!qspi_csb) begin
            if (raw_mode) present(edges);
            else if (edges >= pre) present(edges - pre);
        end
    end

endmodule

// File: bench/qspinor_patterns.txt
# op f1 f2 f3 f4 (hex); N mode cmd dummies, R addr size data, T byte, X data,
# D count edges, F ip addr write size, B busy probe, W addr size data
N 111 03 0 0
R 000010 1 000000b5 0
R 000020 2 00008485 0
R 123404 4 a2a3a0a1 0
R 1234fe 2 00005a5b 0
N 114 6b 8 0
R abcdef 1 0000004a 0
R 000204 4 a2a3a0a1 0
N 144 eb 6 0
R 00f0f2 2 00005657 0
R 345600 4 a6a7a4a5 0
N 444 eb 4 0
R 000011 1 000000b4 0
R 777778 4 dedfdcdd 0
F 0 000001 0 2
F 0 000002 0 4
F 0 000000 1 1
F 1 000001 0 2
F 1 000000 1 1
F 1 000002 0 1
B 0 0 0 0
T 5a 0 0 0
T c3 0 0 0
X 3c 0 0 0
D 3 3 0 0
D 0 10 0 0
N 111 03 0 0
W 000030 2 00009495 0
N 122 bb 2 0
R 000040 1 000000e5 0

// File: bench/qspinor_tb.sv
module qspinor_tb import qspinor_pkg::*; ();
    localparam string pattern_file = "bench/qspinor_patterns.txt";

    logic        clk = 1'b0;
    logic        rstn;
    bus_req_t    nor_bus;
    bus_req_t    ip_bus;
    bus_rsp_t    nor_rsp;
    bus_rsp_t    ip_rsp;
    logic        qspi_csb;
    logic        qspi_sclk;
    logic [3:0]  qspi_dir;
    logic [3:0]  qspi_mosi;
    logic [3:0]  qspi_miso;
    logic        raw_mode;
    logic [2:0]  cmd_w;
    logic [2:0]  addr_w;
    logic [2:0]  data_w;
    logic [3:0]  dmy_n;
    logic [7:0]  cmd_q;
    logic [7:0]  raw_q;
    logic [23:0] addr_q;
    int          edges;
    logic [7:0]  cfg_cmd;
    int          n_steps = 0;

    qspinor_controller i_dut (
        .clk(clk), .rstn(rstn),
        .nor_bus(nor_bus), .nor_rsp(nor_rsp),
        .ip_bus(ip_bus), .ip_rsp(ip_rsp),
        .qspi_csb(qspi_csb), .qspi_sclk(qspi_sclk), .qspi_dir(qspi_dir),
        .qspi_mosi(qspi_mosi), .qspi_miso(qspi_miso)
    );

    qspinor_flash_model i_flash (
        .qspi_csb(qspi_csb), .qspi_sclk(qspi_sclk), .qspi_dir(qspi_dir),
        .qspi_mosi(qspi_mosi), .qspi_miso(qspi_miso),
        .raw_mode(raw_mode), .cmd_w(cmd_w), .addr_w(addr_w), .data_w(data_w),
        .dmy_n(dmy_n), .cmd_q(cmd_q), .addr_q(addr_q), .raw_q(raw_q),
        .edges(edges)
    );

    always #4 clk = ~clk;

    task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            $display("Fail at %0t: %s, got %h expected %h", $time, what, got, exp);
            $display("** FAIL **");
            $fatal(1);
        end
    endtask

    function automatic bus_acc_e size_acc(input logic [31:0] size);
        case (size)
            32'd1:   size_acc = acc_1b;
            32'd2:   size_acc = acc_2b;
            default: size_acc = acc_4b;
        endcase
    endfunction

    // read mode digits to the norcsr mode code
    function automatic logic [2:0] mode_code(input logic [11:0] m);
        case (m)
            12'h112: mode_code = 3'd1;
            12'h114: mode_code = 3'd2;
            12'h122: mode_code = 3'd3;
            12'h144: mode_code = 3'd4;
            12'h222: mode_code = 3'd5;
            12'h444: mode_code = 3'd6;
            default: mode_code = 3'd0;
        endcase
    endfunction

    task automatic ip_access(input logic [2:0] addr, input logic w, input bus_acc_e acc,
                             input logic [31:0] wdata, output logic [31:0] rdata);
        bus_req_t r;
        r       = '0;
        r.addr  = 24'(addr);
        r.w_rb  = w;
        r.acc   = acc;
        r.wdata = wdata;
        r.req   = 1'b1;
        @(posedge clk);
        ip_bus <= r;
        @(negedge clk);
        check(32'(ip_rsp.fault), 32'd0, "register access faulted");
        @(posedge clk);
        ip_bus <= '0;
        @(negedge clk);
        check(32'(ip_rsp.resp), 32'd1, "register access resp");
        rdata = ip_rsp.rdata;
    endtask

    task automatic fault_probe(input logic on_ip, input logic [23:0] addr, input logic w,
                               input bus_acc_e acc);
        bus_req_t r;
        r      = '0;
        r.addr = addr;
        r.w_rb = w;
        r.acc  = acc;
        r.req  = 1'b1;
        @(posedge clk);
        if (on_ip) ip_bus <= r;
        else nor_bus <= r;
        @(negedge clk);
        check(32'(on_ip ? ip_rsp.fault : nor_rsp.fault), 32'd1, "fault missing");
        @(posedge clk);
        ip_bus  <= '0;
        nor_bus <= '0;
        @(negedge clk);
        check(32'(ip_rsp.resp | nor_rsp.resp), 32'd0, "resp after fault");
    endtask

    task automatic wait_idle();
        logic [31:0] d;
        do ip_access(reg_ipcsr, 1'b0, acc_2b, 32'h0, d);
        while (d[ipcsr_busy]);
    endtask

    task automatic deselect();
        logic [31:0] d;
        ip_access(reg_ipcsr, 1'b1, acc_2b, 32'h0, d);
        check(32'(qspi_csb), 32'd1, "csb after deselect");
    endtask

    task automatic read_start(input logic [23:0] addr, input bus_acc_e acc);
        bus_req_t r;
        r      = '0;
        r.addr = addr;
        r.acc  = acc;
        r.req  = 1'b1;
        @(posedge clk);
        nor_bus <= r;
        @(negedge clk);
        check(32'(nor_rsp.fault), 32'd0, "bus read faulted");
        @(posedge clk);
        nor_bus <= '0;
    endtask

    task automatic read_finish(input logic [23:0] addr, input logic [31:0] size,
                               input logic [31:0] exp);
        int n_edges;
        // cmd, address, dummy and data pulses
        n_edges = 8 / int'(cmd_w) + 24 / int'(addr_w) + int'(dmy_n) +
                  int'(size) * 8 / int'(data_w);
        do @(negedge clk);
        while (!nor_rsp.resp);
        check(nor_rsp.rdata, exp, "bus read data");
        check(32'(cmd_q), 32'(cfg_cmd), "flash command");
        check(32'(addr_q), 32'(addr), "flash address");
        check(32'(edges), 32'(n_edges), "sclk pulses in the read");
    endtask

    initial begin
        int          fd;
        int          code;
        logic [7:0]  op;
        logic [31:0] f1, f2, f3, f4;
        logic [31:0] d;
        string       line;
        rstn     = 1'b0;
        nor_bus  = '0;
        ip_bus   = '0;
        raw_mode = 1'b0;
        cmd_w    = 3'd1;
        addr_w   = 3'd1;
        data_w   = 3'd1;
        dmy_n    = 4'd0;
        cfg_cmd  = 8'h0;
        fd = $fopen(pattern_file, "r");
        if (fd == 0) begin
            $display("cannot open the pattern file %s", pattern_file);
            $display("** FAIL **");
            $fatal(1);
        end
        forever begin  // first pass only counts steps for the watchdog
            code = $fscanf(fd, " %c", op);
            if (code != 1) break;
            if (op == "#") code = $fgets(line, fd);
            else begin
                code    = $fscanf(fd, "%h %h %h %h", f1, f2, f3, f4);
                n_steps = n_steps + 1;
            end
        end
        $fclose(fd);
        fd = $fopen(pattern_file, "r");
        repeat (4) @(posedge clk);
        rstn <= 1'b1;
        @(negedge clk);
        check(32'(qspi_csb), 32'd1, "csb after reset");
        check(32'({nor_rsp.resp, nor_rsp.fault, ip_rsp.resp, ip_rsp.fault}), 32'd0,
              "responses after reset");
        forever begin
            code = $fscanf(fd, " %c", op);
            if (code != 1) break;
            if (op == "#") begin
                code = $fgets(line, fd);
                continue;
            end
            code = $fscanf(fd, "%h %h %h %h", f1, f2, f3, f4);
            case (op)
                "N": begin
                    cfg_cmd  = f2[7:0];
                    cmd_w    = 3'(f1[11:8]);
                    addr_w   = 3'(f1[7:4]);
                    data_w   = 3'(f1[3:0]);
                    dmy_n    = f3[3:0];
                    raw_mode = 1'b0;
                    ip_access(reg_norcsr, 1'b1, acc_2b,
                              {16'h0, f2[7:0], f3[3:0], 1'b0, mode_code(f1[11:0])}, d);
                end
                "R": begin
                    raw_mode = 1'b0;
                    read_start(f1[23:0], size_acc(f2));
                    read_finish(f1[23:0], f2, f3);
                end
                "T": begin
                    raw_mode = 1'b1;
                    ip_access(reg_txd, 1'b1, acc_1b, {24'h0, f1[7:0]}, d);
                    ip_access(reg_ipcsr, 1'b1, acc_2b, 32'h0011, d);
                    wait_idle();
                    check(32'(raw_q), f1, "byte seen by flash");
                    deselect();
                end
                "X": begin
                    raw_mode = 1'b1;
                    ip_access(reg_ipcsr, 1'b1, acc_2b, 32'h0001, d);
                    wait_idle();
                    ip_access(reg_rxd, 1'b0, acc_1b, 32'h0, d);
                    check(d, f1, "received byte");
                    deselect();
                end
                "D": begin
                    raw_mode = 1'b1;
                    ip_access(reg_ipcsr, 1'b1, acc_2b, {16'h0, 4'h0, f1[3:0], 8'h21}, d);
                    wait_idle();
                    check(32'(edges), f2, "dummy burst length");
                    deselect();
                end
                "F": fault_probe(f1[0], f2[23:0], f3[0], size_acc(f4));
                "B": begin  // ipcsr write during a 16 pulse burst
                    raw_mode = 1'b1;
                    ip_access(reg_ipcsr, 1'b1, acc_2b, 32'h0021, d);
                    fault_probe(1'b1, 24'h0, 1'b1, acc_2b);
                    wait_idle();
                    deselect();
                end
                "W": begin  // read must wait for the register path
                    raw_mode = 1'b0;
                    ip_access(reg_ipcsr, 1'b1, acc_2b, 32'h0121, d);
                    wait_idle();
                    read_start(f1[23:0], size_acc(f2));
                    repeat (40) begin
                        @(negedge clk);
                        check(32'(nor_rsp.resp), 32'd0, "read resp while flash is held");
                        check(32'(qspi_sclk), 32'd0, "sclk while flash is held");
                    end
                    deselect();
                    read_finish(f1[23:0], f2, f3);
                end
                default: begin
                    $display("unknown operation in the pattern file: %c", op);
                    $display("** FAIL **");
                    $fatal(1);
                end
            endcase
        end
        $fclose(fd);
        $display("** PASS **");
        $finish;
    end

    initial begin
        wait (n_steps > 0);
        repeat (n_steps * 200) @(posedge clk);
        $display("timeout: run still going after %0d cycles", n_steps * 200);
        $display("** FAIL **");
        $fatal(1);
    end

endmodule

// File: source/qspinor_bus_read.sv
module qspinor_bus_read import qspinor_pkg::*; (
    input  logic     clk,
    input  logic     rstn,
    input  bus_req_t bus,
    output bus_rsp_t rsp,
    input  nor_cfg_t nor_cfg,
    input  logic     ip_csb,
    output io_req_t  io_req,
    input  io_rsp_t  io_rsp,
    output logic     csb
);
    typedef enum logic [2:0] {idle, wait_bus, prep, cmd, addr, dmy, data} state_e;

    state_e                  state, next_state;
    logic [3:0]              cnt, next_cnt;
    logic [nor_va_width-1:0] req_addr;
    bus_acc_e                req_acc;
    logic [1:0]              last_byte;
    logic [1:0]              byte_idx;
    logic [bus_width-1:0]    rdata_q;
    logic                    resp_q;
    logic                    invld;
    logic                    accept;
    logic                    issue;

    assign invld = bus.w_rb ||
                   (bus.addr[0] && bus.acc != acc_1b) ||
                   (bus.addr[1:0] == 2'd2 && bus.acc == acc_4b);
    assign accept = bus.req && !invld && (state == idle);

    assign last_byte = (req_acc == acc_4b) ? 2'd3 :
                       (req_acc == acc_2b) ? 2'd1 : 2'd0;
    assign byte_idx  = last_byte - cnt[1:0];  // little endian

    always_comb begin
        next_state = state;
        next_cnt   = cnt;
        case (state)
            idle: if (accept) begin
                next_state = wait_bus;
                next_cnt   = 4'd1;
            end
            wait_bus: if (ip_csb) begin  // hold while register path owns the flash
                if (cnt == 4'd0) next_state = prep;
                else next_cnt = cnt - 4'd1;
            end
            prep: next_state = cmd;
            cmd: if (io_rsp.tx_resp) begin
                next_state = addr;
                next_cnt   = 4'd2;
            end
            addr: if (io_rsp.tx_resp) begin
                if (cnt != 4'd0) begin
                    next_cnt = cnt - 4'd1;
                end else if (nor_cfg.dmy_cnt != 4'd0) begin
                    next_state = dmy;
                    next_cnt   = nor_cfg.dmy_cnt;
                end else begin
                    next_state = data;
                    next_cnt   = {2'b00, last_byte};
                end
            end
            dmy: if (io_rsp.dmy_resp) begin
                if (cnt == 4'd1) begin
                    next_state = data;
                    next_cnt   = {2'b00, last_byte};
                end else begin
                    next_cnt = cnt - 4'd1;
                end
            end
            data: if (io_rsp.rx_resp) begin
                if (cnt == 4'd0) next_state = idle;
                else next_cnt = cnt - 4'd1;
            end
            default: next_state = idle;
        endcase
    end

    // next unit goes out in the cycle the previous one ends
    assign issue = (state == prep) ||
                   ((state == cmd || state == addr) && io_rsp.tx_resp) ||
                   (state == dmy && io_rsp.dmy_resp) ||
                   (state == data && io_rsp.rx_resp);

    always_comb begin
        io_req         = '0;
        io_req.dmy_dir = nor_cfg.dmy_dir;
        case (next_state)
            cmd: begin
                io_req.tx_req = issue;
                io_req.width  = nor_cfg.cmd_width;
                io_req.txd    = nor_cfg.cmd_octet;
            end
            addr: begin
                io_req.tx_req = issue;
                io_req.width  = nor_cfg.addr_width;
                io_req.txd    = req_addr[{next_cnt[1:0], 3'b000} +: 8];
            end
            dmy: begin
                io_req.dmy_req = issue;
                io_req.width   = nor_cfg.dmy_width;
            end
            data: begin
                io_req.rx_req = issue;
                io_req.width  = nor_cfg.data_width;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state  <= idle;
            cnt    <= 4'd0;
            csb    <= 1'b1;
            resp_q <= 1'b0;
        end else begin
            state  <= next_state;
            cnt    <= next_cnt;
            resp_q <= (state == data) && (next_state == idle);
            if (next_state == idle) csb <= 1'b1;
            else if (next_state == prep) csb <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req_addr <= bus.addr;
            req_acc  <= bus.acc;
            rdata_q  <= '0;
        end else if (state == data && io_rsp.rx_resp) begin
            rdata_q[{byte_idx, 3'b000} +: 8] <= io_rsp.rxd;
        end
    end

    assign rsp.rdata = rdata_q;
    assign rsp.resp  = resp_q;
    assign rsp.fault = bus.req && invld;

endmodule

// File: source/qspinor_controller.sv
module qspinor_controller import qspinor_pkg::*; (
    input  logic       clk,
    input  logic       rstn,
    input  bus_req_t   nor_bus,
    output bus_rsp_t   nor_rsp,
    input  bus_req_t   ip_bus,
    output bus_rsp_t   ip_rsp,
    output logic       qspi_csb,
    output logic       qspi_sclk,
    output logic [3:0] qspi_dir,
    output logic [3:0] qspi_mosi,
    input  logic [3:0] qspi_miso
);
    nor_cfg_t nor_cfg;
    io_req_t  nor_io_req, ip_io_req, io_req;
    io_rsp_t  io_rsp;
    logic     nor_csb, ip_csb;

    qspinor_bus_read i_bus_read (
        .clk(clk), .rstn(rstn),
        .bus(nor_bus), .rsp(nor_rsp),
        .nor_cfg(nor_cfg), .ip_csb(ip_csb),
        .io_req(nor_io_req), .io_rsp(io_rsp),
        .csb(nor_csb)
    );

    qspinor_ip_access i_ip_access (
        .clk(clk), .rstn(rstn),
        .bus(ip_bus), .rsp(ip_rsp),
        .nor_cfg(nor_cfg), .csb(ip_csb),
        .io_req(ip_io_req), .io_rsp(io_rsp)
    );

    assign io_req   = nor_csb ? ip_io_req : nor_io_req;  // read path owns the engine while selected
    assign qspi_csb = nor_csb & ip_csb;

    qspinor_io i_io (
        .clk(clk), .rstn(rstn),
        .io_req(io_req), .io_rsp(io_rsp),
        .qspi_sclk(qspi_sclk), .qspi_dir(qspi_dir),
        .qspi_mosi(qspi_mosi), .qspi_miso(qspi_miso)
    );

endmodule

// File: source/qspinor_io.sv
module qspinor_io import qspinor_pkg::*; (
    input  logic       clk,
    input  logic       rstn,
    input  io_req_t    io_req,
    output io_rsp_t    io_rsp,
    output logic       qspi_sclk,
    output logic [3:0] qspi_dir,
    output logic [3:0] qspi_mosi,
    input  logic [3:0] qspi_miso
);
    typedef enum logic [2:0] {idle, tx, rx, dmy_out, dmy_in} state_e;

    state_e      state;
    logic [3:0]  cnt;
    lane_width_e width_q;
    logic [7:0]  txd_q;
    logic [7:0]  rxd_q;
    logic [3:0]  pattern_q;
    logic [3:0]  lane_mask;
    logic        start;

    function automatic logic [3:0] byte_cycles(lane_width_e w);
        case (w)
            x1:      byte_cycles = 4'd15;
            x2:      byte_cycles = 4'd7;
            default: byte_cycles = 4'd3;
        endcase
    endfunction

    // a new request is taken when idle or in the last cycle of a unit
    assign start = (cnt == 4'd0) && (io_req.tx_req || io_req.rx_req || io_req.dmy_req);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= idle;
            cnt   <= 4'd0;
        end else if (cnt == 4'd0) begin
            if (io_req.tx_req) begin
                state <= tx;
                cnt   <= byte_cycles(io_req.width);
            end else if (io_req.rx_req) begin
                state <= rx;
                cnt   <= byte_cycles(io_req.width);
            end else if (io_req.dmy_req) begin
                state <= io_req.dmy_dir ? dmy_out : dmy_in;
                cnt   <= 4'(dmy_cycles - 1);
            end else begin
                state <= idle;
            end
        end else begin
            cnt <= cnt - 4'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            width_q   <= io_req.width;
            txd_q     <= io_req.txd;
            pattern_q <= io_req.dmy_pattern;
        end
        // sample on the cycle before sclk rises
        if (state == rx && cnt[0]) begin
            case (width_q)
                x1:      rxd_q <= {rxd_q[6:0], qspi_miso[1]};
                x2:      rxd_q <= {rxd_q[5:0], qspi_miso[1:0]};
                default: rxd_q <= {rxd_q[3:0], qspi_miso};
            endcase
        end
    end

    assign lane_mask = (width_q == x1) ? 4'b0001 :
                       (width_q == x2) ? 4'b0011 : 4'b1111;

    assign qspi_sclk = (state != idle) && !cnt[0];  // mode 0, idles low

    always_comb begin
        qspi_dir  = 4'h0;
        qspi_mosi = 4'h0;
        case (state)
            tx: begin
                qspi_dir = lane_mask;
                case (width_q)  // msb first
                    x1:      qspi_mosi = {3'b000, txd_q[cnt[3:1]]};
                    x2:      qspi_mosi = {2'b00, txd_q[{cnt[2:1], 1'b0} +: 2]};
                    default: qspi_mosi = txd_q[{cnt[1], 2'b00} +: 4];
                endcase
            end
            dmy_out: begin
                qspi_dir  = lane_mask;
                qspi_mosi = pattern_q;
            end
            default: ;
        endcase
    end

    assign io_rsp.tx_resp  = (state == tx) && (cnt == 4'd0);
    assign io_rsp.rx_resp  = (state == rx) && (cnt == 4'd0);
    assign io_rsp.dmy_resp = (state == dmy_out || state == dmy_in) && (cnt == 4'd0);
    assign io_rsp.rxd      = rxd_q;

endmodule

// File: source/qspinor_ip_access.sv
module qspinor_ip_access import qspinor_pkg::*; (
    input  logic     clk,
    input  logic     rstn,
    input  bus_req_t bus,
    output bus_rsp_t rsp,
    output nor_cfg_t nor_cfg,
    output logic     csb,
    output io_req_t  io_req,
    input  io_rsp_t  io_rsp
);
    typedef enum logic [1:0] {idle, tx, rx, dmy} state_e;

    state_e                 state;
    logic [4:0]             cnt;
    logic [ip_va_width-1:0] reg_addr;
    logic                   invld;
    logic                   ok;
    logic                   ipcsr_wr;
    logic                   start;
    logic                   busy;
    logic                   kick;
    logic [3:0]             count;
    logic [15:0]            norcsr;
    logic [15:0]            ipcsr_rd;
    lane_width_e            ip_width;
    logic                   ip_dir;
    logic [3:0]             ip_pattern;
    logic [7:0]             txd_q;
    logic [7:0]             rxd_q;
    logic [bus_width-1:0]   rdata_q;
    logic                   resp_q;
    read_mode_e             mode;

    assign reg_addr = bus.addr[ip_va_width-1:0];
    assign busy     = (state != idle);

    always_comb begin
        case (reg_addr)
            reg_ipcsr:  invld = (bus.acc != acc_2b) || (bus.w_rb && busy);
            reg_norcsr: invld = (bus.acc != acc_2b);
            reg_txd:    invld = (bus.acc != acc_1b) || !bus.w_rb;
            reg_rxd:    invld = (bus.acc != acc_1b) || bus.w_rb;
            default:    invld = 1'b1;
        endcase
    end

    assign ok       = bus.req && !invld;
    assign ipcsr_wr = ok && bus.w_rb && (reg_addr == reg_ipcsr);
    assign start    = ipcsr_wr && bus.wdata[ipcsr_sel];
    assign count    = bus.wdata[ipcsr_count_lsb +: 4];

    always_ff @(posedge clk) begin
        if (!rstn) begin
            resp_q <= 1'b0;
            kick   <= 1'b0;
            csb    <= 1'b1;
            norcsr <= 16'h0;
        end else begin
            resp_q <= ok;
            kick   <= start;  // first engine strobe one cycle later
            if (ipcsr_wr) csb <= !bus.wdata[ipcsr_sel];
            if (ok && bus.w_rb && reg_addr == reg_norcsr) norcsr <= bus.wdata[15:0];
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= idle;
            cnt   <= 5'd0;
        end else begin
            case (state)
                idle: if (start) begin
                    if (bus.wdata[ipcsr_dummy]) begin
                        state <= dmy;
                        cnt   <= (count == 4'd0) ? 5'd16 : {1'b0, count};
                    end else if (bus.wdata[ipcsr_dir]) begin
                        state <= tx;
                    end else begin
                        state <= rx;
                    end
                end
                tx: if (io_rsp.tx_resp) state <= idle;
                rx: if (io_rsp.rx_resp) state <= idle;
                dmy: if (io_rsp.dmy_resp) begin
                    if (cnt == 5'd1) state <= idle;
                    cnt <= cnt - 5'd1;
                end
                default: state <= idle;
            endcase
        end
    end

    always_comb begin
        ipcsr_rd             = 16'h0;
        ipcsr_rd[ipcsr_busy] = busy;
        ipcsr_rd[ipcsr_sel]  = !csb;
    end

    always_ff @(posedge clk) begin
        if (ipcsr_wr) begin
            ip_width   <= lane_width_e'(bus.wdata[ipcsr_width_lsb +: 2]);
            ip_dir     <= bus.wdata[ipcsr_dir];
            ip_pattern <= bus.wdata[ipcsr_pattern_lsb +: 4];
        end
        if (ok && bus.w_rb && reg_addr == reg_txd) txd_q <= bus.wdata[7:0];
        if (state == rx && io_rsp.rx_resp) rxd_q <= io_rsp.rxd;
        if (ok && !bus.w_rb) begin
            case (reg_addr)
                reg_ipcsr: rdata_q <= {16'h0, ipcsr_rd};
                reg_rxd:   rdata_q <= {24'h0, rxd_q};
                default:   rdata_q <= {16'h0, norcsr};
            endcase
        end
    end

    always_comb begin
        io_req             = '0;
        io_req.tx_req      = kick && (state == tx);
        io_req.rx_req      = kick && (state == rx);
        io_req.dmy_req     = (state == dmy) && (kick || (io_rsp.dmy_resp && cnt != 5'd1));
        io_req.width       = ip_width;
        io_req.txd         = txd_q;
        io_req.dmy_dir     = ip_dir;
        io_req.dmy_pattern = ip_pattern;
    end

    // read mode to lane widths, dummy runs at address width
    always_comb begin
        mode               = read_mode_e'(norcsr[norcsr_mode_lsb +: 3]);
        nor_cfg            = '0;
        nor_cfg.cmd_octet  = norcsr[norcsr_cmd_lsb +: 8];
        nor_cfg.dmy_cnt    = norcsr[norcsr_dmy_cnt_lsb +: 4];
        nor_cfg.dmy_dir    = norcsr[norcsr_dmy_dir];
        nor_cfg.cmd_width  = (mode == mode_444) ? x4 : (mode == mode_222) ? x2 : x1;
        case (mode)
            mode_112: nor_cfg.data_width = x2;
            mode_114: nor_cfg.data_width = x4;
            mode_122, mode_222: begin
                nor_cfg.addr_width = x2;
                nor_cfg.data_width = x2;
            end
            mode_144, mode_444: begin
                nor_cfg.addr_width = x4;
                nor_cfg.data_width = x4;
            end
            default: ;
        endcase
        nor_cfg.dmy_width = nor_cfg.addr_width;
    end

    assign rsp.rdata = rdata_q;
    assign rsp.resp  = resp_q;
    assign rsp.fault = bus.req && invld;

endmodule

// File: source/qspinor_pkg.sv
package qspinor_pkg;

    localparam int bus_width    = 32;
    localparam int nor_va_width = 24;
    localparam int ip_va_width  = 3;

    // register path address map
    localparam logic [ip_va_width-1:0] reg_ipcsr  = 3'd0;
    localparam logic [ip_va_width-1:0] reg_txd    = 3'd2;
    localparam logic [ip_va_width-1:0] reg_rxd    = 3'd3;
    localparam logic [ip_va_width-1:0] reg_norcsr = 3'd6;

    // ipcsr fields
    localparam int ipcsr_sel         = 0;
    localparam int ipcsr_busy        = 1;
    localparam int ipcsr_dir         = 4;  // 1 = out
    localparam int ipcsr_dummy       = 5;
    localparam int ipcsr_width_lsb   = 6;  // 7:6
    localparam int ipcsr_count_lsb   = 8;  // 11:8
    localparam int ipcsr_pattern_lsb = 12; // 15:12

    // norcsr fields
    localparam int norcsr_mode_lsb    = 0; // 2:0
    localparam int norcsr_dmy_dir     = 3;
    localparam int norcsr_dmy_cnt_lsb = 4; // 7:4
    localparam int norcsr_cmd_lsb     = 8; // 15:8

    localparam int dmy_cycles = 2;  // one sclk pulse

    typedef enum logic [1:0] {x1, x2, x4} lane_width_e;
    typedef enum logic [1:0] {acc_1b, acc_2b, acc_4b} bus_acc_e;
    typedef enum logic [2:0] {
        mode_111, mode_112, mode_114, mode_122, mode_144, mode_222, mode_444
    } read_mode_e;

    typedef struct packed {
        logic [nor_va_width-1:0] addr;
        logic                    w_rb;
        bus_acc_e                acc;
        logic [bus_width-1:0]    wdata;
        logic                    req;
    } bus_req_t;

    typedef struct packed {
        logic [bus_width-1:0] rdata;
        logic                 resp;
        logic                 fault;
    } bus_rsp_t;

    typedef struct packed {
        logic        tx_req;
        logic        rx_req;
        logic        dmy_req;
        lane_width_e width;
        logic [7:0]  txd;
        logic        dmy_dir;
        logic [3:0]  dmy_pattern;
    } io_req_t;

    typedef struct packed {
        logic       tx_resp;
        logic       rx_resp;
        logic       dmy_resp;
        logic [7:0] rxd;
    } io_rsp_t;

    typedef struct packed {
        lane_width_e cmd_width;
        lane_width_e addr_width;
        lane_width_e dmy_width;
        lane_width_e data_width;
        logic [7:0]  cmd_octet;
        logic [3:0]  dmy_cnt;
        logic        dmy_dir;
    } nor_cfg_t;

endpackage
